/* rtl/dcache_pkg.sv */
package dcache_pkg;

    // address and data geometry
    localparam int ADDR_W         = 32;
    localparam int WORD_W         = 32;
    localparam int WORDS_PER_LINE = 8;
    localparam int OFFSET_W       = 5;
    localparam int LINE_W         = WORD_W * WORDS_PER_LINE;

    typedef logic [2:0] word_sel_t;

    // one cache line, flat for the memory bus, split into words for the store
    typedef union packed {
        logic [LINE_W-1:0]                    flat;
        logic [WORDS_PER_LINE-1:0][WORD_W-1:0] words;
    } line_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_COMPARE,
        ST_WRITEBACK,
        ST_REFILL
    } cache_state_e;

    // word index inside the line, address bits 4:2
    function automatic word_sel_t word_sel(input logic [ADDR_W-1:0] addr);
        return addr[OFFSET_W-1:2];
    endfunction

    // line-aligned byte address
    function automatic logic [ADDR_W-1:0] line_addr(input logic [ADDR_W-1:0] addr);
        return {addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
    endfunction

    // replace the enabled bytes of old_word with new_word
    function automatic logic [WORD_W-1:0] merge_word(
        input logic [WORD_W-1:0] old_word,
        input logic [WORD_W-1:0] new_word,
        input logic [3:0]        sel
    );
        logic [WORD_W-1:0] mask;
        mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
        return (new_word & mask) | (old_word & ~mask);
    endfunction

endpackage

/* rtl/dcache_ctrl.sv */
`timescale 1ns/1ns

module dcache_ctrl
    import dcache_pkg::*;
(
    input  logic              clk,
    input  logic              rst,

    // cpu request
    input  logic              rreq_i,
    input  logic              wreq_i,
    input  logic [ADDR_W-1:0] addr_i,
    input  logic [WORD_W-1:0] wdata_i,
    input  logic [3:0]        wsel_i,
    output logic              stall_o,
    output logic              hit_o,
    output logic [WORD_W-1:0] rdata_o,
    output logic              rdata_valid_o,

    // captured request towards the stores
    output logic [ADDR_W-1:0] req_addr_o,
    output logic              req_is_write_o,
    output logic [WORD_W-1:0] req_wdata_o,
    output logic [3:0]        req_wsel_o,
    output logic              lookup_done_o,

    // tag store results
    input  logic              hit_way0_i,
    input  logic              hit_way1_i,
    input  logic              victim_dirty_i,

    // memory port commands and status
    output logic              wb_start_o,
    output logic              refill_start_o,
    input  logic              wb_done_i,
    input  logic              refill_done_i,
    input  logic [WORD_W-1:0] refill_word_i,

    // addressed word of each way
    input  logic [WORD_W-1:0] way0_word_i,
    input  logic [WORD_W-1:0] way1_word_i
);

    cache_state_e state_q;
    cache_state_e state_d;

    logic accept;
    logic any_hit;
    logic in_compare;
    logic in_refill;
    logic miss;

    assign accept     = (state_q == ST_IDLE) && (rreq_i || wreq_i);
    assign any_hit    = hit_way0_i || hit_way1_i;
    assign in_compare = (state_q == ST_COMPARE);
    assign in_refill  = (state_q == ST_REFILL);
    assign miss       = in_compare && !any_hit;

    //////////////////////////////
    // request capture
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr_o     <= addr_i;
            req_is_write_o <= wreq_i;
            req_wdata_o    <= wdata_i;
            req_wsel_o     <= wsel_i;
        end
    end

    //////////////////////////////
    // state machine
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (accept) begin
                    state_d = ST_COMPARE;
                end
            end
            ST_COMPARE: begin
                if (any_hit) begin
                    state_d = ST_IDLE;
                end else if (victim_dirty_i) begin
                    state_d = ST_WRITEBACK;
                end else begin
                    state_d = ST_REFILL;
                end
            end
            ST_WRITEBACK: begin
                // victim must reach memory before the refill starts
                if (wb_done_i) begin
                    state_d = ST_REFILL;
                end
            end
            ST_REFILL: begin
                if (refill_done_i) begin
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    // commands to the memory port
    assign wb_start_o     = miss && victim_dirty_i;
    assign refill_start_o = (miss && !victim_dirty_i)
                          || ((state_q == ST_WRITEBACK) && wb_done_i);
    assign lookup_done_o  = in_compare;

    //////////////////////////////
    // cpu outputs
    //////////////////////////////

    assign stall_o = (state_q != ST_IDLE);
    assign hit_o   = in_compare && any_hit;

    // read data from the hit way, or straight from the refill line
    always_comb begin
        if (in_refill) begin
            rdata_o = refill_word_i;
        end else if (hit_way1_i) begin
            rdata_o = way1_word_i;
        end else begin
            rdata_o = way0_word_i;
        end
    end

    assign rdata_valid_o = !req_is_write_o
                         && ((in_compare && any_hit) || (in_refill && refill_done_i));

endmodule

/* rtl/dcache_tag_store.sv */
`timescale 1ns/1ns

module dcache_tag_store
    import dcache_pkg::*;
#(
    parameter int NUM_SETS = 64
) (
    input  logic              clk,
    input  logic              rst,

    input  logic [ADDR_W-1:0] req_addr_i,
    input  logic              req_is_write_i,
    input  logic              lookup_done_i,
    input  logic              refill_done_i,

    output logic              hit_way0_o,
    output logic              hit_way1_o,
    output logic              victim_way_o,
    output logic              victim_dirty_o,
    output logic [ADDR_W-$clog2(NUM_SETS)-OFFSET_W-1:0] victim_tag_o
);

    localparam int IDX_W = $clog2(NUM_SETS);
    localparam int TAG_W = ADDR_W - IDX_W - OFFSET_W;

    // per way arrays
    logic [TAG_W-1:0]    tag_q   [2][NUM_SETS];
    logic [NUM_SETS-1:0] valid_q [2];
    logic [NUM_SETS-1:0] dirty_q [2];

    // lru bit names the way to evict next
    logic [NUM_SETS-1:0] lru_q;

    logic [IDX_W-1:0] idx;
    logic [TAG_W-1:0] req_tag;
    logic             any_hit;

    assign idx     = req_addr_i[OFFSET_W +: IDX_W];
    assign req_tag = req_addr_i[ADDR_W-1 -: TAG_W];

    //////////////////////////////
    // compare and victim select
    //////////////////////////////

    assign hit_way0_o = valid_q[0][idx] && (tag_q[0][idx] == req_tag);
    assign hit_way1_o = valid_q[1][idx] && (tag_q[1][idx] == req_tag);
    assign any_hit    = hit_way0_o || hit_way1_o;

    assign victim_way_o   = lru_q[idx];
    assign victim_dirty_o = valid_q[victim_way_o][idx] && dirty_q[victim_way_o][idx];
    assign victim_tag_o   = tag_q[victim_way_o][idx];

    //////////////////////////////
    // state update
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q[0] <= '0;
            valid_q[1] <= '0;
            dirty_q[0] <= '0;
            dirty_q[1] <= '0;
            lru_q      <= '0;
        end else if (lookup_done_i && any_hit) begin
            // point lru away from the way just used
            lru_q[idx] <= hit_way0_o;
            if (req_is_write_i) begin
                dirty_q[hit_way1_o][idx] <= 1'b1;
            end
        end else if (refill_done_i) begin
            valid_q[victim_way_o][idx] <= 1'b1;
            dirty_q[victim_way_o][idx] <= req_is_write_i;
            lru_q[idx]                 <= ~lru_q[idx];
        end
    end

    // new tag goes in with the refilled line
    always_ff @(posedge clk) begin
        if (refill_done_i) begin
            tag_q[victim_way_o][idx] <= req_tag;
        end
    end

endmodule

/* rtl/dcache_data_store.sv */
`timescale 1ns/1ns

module dcache_data_store
    import dcache_pkg::*;
#(
    parameter int NUM_SETS = 64
) (
    input  logic              clk,
    input  logic              rst,

    input  logic [ADDR_W-1:0] req_addr_i,
    input  logic              req_is_write_i,
    input  logic [WORD_W-1:0] req_wdata_i,
    input  logic [3:0]        req_wsel_i,
    input  logic              hit_way0_i,
    input  logic              hit_way1_i,
    input  logic              lookup_done_i,
    input  logic              victim_way_i,
    input  logic              refill_done_i,
    input  line_t             refill_line_i,

    output logic [WORD_W-1:0] way0_word_o,
    output logic [WORD_W-1:0] way1_word_o,
    output line_t             victim_line_o
);

    localparam int IDX_W = $clog2(NUM_SETS);

    line_t lines_q [2][NUM_SETS];

    logic [IDX_W-1:0] idx;
    word_sel_t        ws;
    logic [1:0]       hit_vec;
    line_t            rd_line [2];
    line_t            hit_line;
    line_t            fill_line;

    assign idx     = req_addr_i[OFFSET_W +: IDX_W];
    assign ws      = word_sel(req_addr_i);
    assign hit_vec = {hit_way1_i, hit_way0_i};

    assign rd_line[0] = lines_q[0][idx];
    assign rd_line[1] = lines_q[1][idx];

    assign way0_word_o   = rd_line[0].words[ws];
    assign way1_word_o   = rd_line[1].words[ws];
    assign victim_line_o = rd_line[victim_way_i];

    // write hit, only the enabled bytes of one word change
    always_comb begin
        hit_line = rd_line[hit_way1_i];
        hit_line.words[ws] = merge_word(hit_line.words[ws], req_wdata_i, req_wsel_i);
    end

    // refill line, with the cpu bytes folded in on a write miss
    always_comb begin
        fill_line = refill_line_i;
        if (req_is_write_i) begin
            fill_line.words[ws] = merge_word(refill_line_i.words[ws], req_wdata_i, req_wsel_i);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int w = 0; w < 2; w++) begin
                if (lookup_done_i && req_is_write_i && hit_vec[w]) begin
                    lines_q[w][idx] <= hit_line;
                end else if (refill_done_i && (victim_way_i == w[0])) begin
                    lines_q[w][idx] <= fill_line;
                end
            end
        end
    end

endmodule

/* rtl/dcache_mem_port.sv */
`timescale 1ns/1ns

module dcache_mem_port
    import dcache_pkg::*;
#(
    parameter int NUM_SETS = 64
) (
    input  logic              clk,
    input  logic              rst,

    // from control and stores
    input  logic [ADDR_W-1:0] req_addr_i,
    input  logic [ADDR_W-$clog2(NUM_SETS)-OFFSET_W-1:0] victim_tag_i,
    input  line_t             victim_line_i,
    input  logic              wb_start_i,
    input  logic              refill_start_i,

    // back to control and stores
    output logic              wb_done_o,
    output logic              refill_done_o,
    output line_t             refill_line_o,
    output logic [WORD_W-1:0] refill_word_o,

    // memory read channel
    output logic              mem_ren_o,
    output logic [ADDR_W-1:0] mem_araddr_o,
    input  logic              mem_rvalid_i,
    input  line_t             mem_rdata_i,

    // memory write channel
    output logic              mem_wen_o,
    output logic [ADDR_W-1:0] mem_awaddr_o,
    output line_t             mem_wdata_o,
    input  logic              mem_bvalid_i
);

    localparam int IDX_W = $clog2(NUM_SETS);

    //////////////////////////////
    // victim write-back
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_wen_o <= 1'b0;
        end else if (wb_start_i) begin
            mem_wen_o <= 1'b1;
        end else if (mem_bvalid_i) begin
            mem_wen_o <= 1'b0;
        end
    end

    // victim address rebuilt from its stored tag and the current set
    always_ff @(posedge clk) begin
        if (wb_start_i) begin
            mem_awaddr_o <= {victim_tag_i, req_addr_i[OFFSET_W +: IDX_W], {OFFSET_W{1'b0}}};
            mem_wdata_o  <= victim_line_i;
        end
    end

    assign wb_done_o = mem_wen_o && mem_bvalid_i;

    //////////////////////////////
    // line refill
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_ren_o <= 1'b0;
        end else if (refill_start_i) begin
            mem_ren_o <= 1'b1;
        end else if (mem_rvalid_i) begin
            mem_ren_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (refill_start_i) begin
            mem_araddr_o <= line_addr(req_addr_i);
        end
    end

    assign refill_done_o = mem_ren_o && mem_rvalid_i;
    assign refill_line_o = mem_rdata_i;
    assign refill_word_o = mem_rdata_i.words[word_sel(req_addr_i)];

endmodule

/* rtl/dcache_top.sv */
`timescale 1ns/1ns

module dcache_top
    import dcache_pkg::*;
#(
    parameter int NUM_SETS = 64
) (
    input  logic              clk,
    input  logic              rst,

    // cpu side
    input  logic              rreq_i,
    input  logic              wreq_i,
    input  logic [ADDR_W-1:0] addr_i,
    input  logic [WORD_W-1:0] wdata_i,
    input  logic [3:0]        wsel_i,
    output logic              stall_o,
    output logic              hit_o,
    output logic [WORD_W-1:0] rdata_o,
    output logic              rdata_valid_o,

    // memory side
    output logic              mem_ren_o,
    output logic [ADDR_W-1:0] mem_araddr_o,
    input  logic              mem_rvalid_i,
    input  line_t             mem_rdata_i,
    output logic              mem_wen_o,
    output logic [ADDR_W-1:0] mem_awaddr_o,
    output line_t             mem_wdata_o,
    input  logic              mem_bvalid_i
);

    localparam int IDX_W = $clog2(NUM_SETS);
    localparam int TAG_W = ADDR_W - IDX_W - OFFSET_W;

    // captured request
    logic [ADDR_W-1:0] req_addr;
    logic              req_is_write;
    logic [WORD_W-1:0] req_wdata;
    logic [3:0]        req_wsel;
    logic              lookup_done;

    // lookup results
    logic              hit_way0;
    logic              hit_way1;
    logic              victim_way;
    logic              victim_dirty;
    logic [TAG_W-1:0]  victim_tag;
    logic [WORD_W-1:0] way0_word;
    logic [WORD_W-1:0] way1_word;
    line_t             victim_line;

    // memory sequencing
    logic              wb_start;
    logic              refill_start;
    logic              wb_done;
    logic              refill_done;
    line_t             refill_line;
    logic [WORD_W-1:0] refill_word;

    dcache_ctrl u_ctrl (
        .clk            (clk),
        .rst            (rst),
        .rreq_i         (rreq_i),
        .wreq_i         (wreq_i),
        .addr_i         (addr_i),
        .wdata_i        (wdata_i),
        .wsel_i         (wsel_i),
        .stall_o        (stall_o),
        .hit_o          (hit_o),
        .rdata_o        (rdata_o),
        .rdata_valid_o  (rdata_valid_o),
        .req_addr_o     (req_addr),
        .req_is_write_o (req_is_write),
        .req_wdata_o    (req_wdata),
        .req_wsel_o     (req_wsel),
        .lookup_done_o  (lookup_done),
        .hit_way0_i     (hit_way0),
        .hit_way1_i     (hit_way1),
        .victim_dirty_i (victim_dirty),
        .wb_start_o     (wb_start),
        .refill_start_o (refill_start),
        .wb_done_i      (wb_done),
        .refill_done_i  (refill_done),
        .refill_word_i  (refill_word),
        .way0_word_i    (way0_word),
        .way1_word_i    (way1_word)
    );

    dcache_tag_store #(
        .NUM_SETS (NUM_SETS)
    ) u_tag_store (
        .clk            (clk),
        .rst            (rst),
        .req_addr_i     (req_addr),
        .req_is_write_i (req_is_write),
        .lookup_done_i  (lookup_done),
        .refill_done_i  (refill_done),
        .hit_way0_o     (hit_way0),
        .hit_way1_o     (hit_way1),
        .victim_way_o   (victim_way),
        .victim_dirty_o (victim_dirty),
        .victim_tag_o   (victim_tag)
    );

    dcache_data_store #(
        .NUM_SETS (NUM_SETS)
    ) u_data_store (
        .clk            (clk),
        .rst            (rst),
        .req_addr_i     (req_addr),
        .req_is_write_i (req_is_write),
        .req_wdata_i    (req_wdata),
        .req_wsel_i     (req_wsel),
        .hit_way0_i     (hit_way0),
        .hit_way1_i     (hit_way1),
        .lookup_done_i  (lookup_done),
        .victim_way_i   (victim_way),
        .refill_done_i  (refill_done),
        .refill_line_i  (refill_line),
        .way0_word_o    (way0_word),
        .way1_word_o    (way1_word),
        .victim_line_o  (victim_line)
    );

    dcache_mem_port #(
        .NUM_SETS (NUM_SETS)
    ) u_mem_port (
        .clk            (clk),
        .rst            (rst),
        .req_addr_i     (req_addr),
        .victim_tag_i   (victim_tag),
        .victim_line_i  (victim_line),
        .wb_start_i     (wb_start),
        .refill_start_i (refill_start),
        .wb_done_o      (wb_done),
        .refill_done_o  (refill_done),
        .refill_line_o  (refill_line),
        .refill_word_o  (refill_word),
        .mem_ren_o      (mem_ren_o),
        .mem_araddr_o   (mem_araddr_o),
        .mem_rvalid_i   (mem_rvalid_i),
        .mem_rdata_i    (mem_rdata_i),
        .mem_wen_o      (mem_wen_o),
        .mem_awaddr_o   (mem_awaddr_o),
        .mem_wdata_o    (mem_wdata_o),
        .mem_bvalid_i   (mem_bvalid_i)
    );

endmodule

/* verification/dcache_sva.sv */
`timescale 1ns/1ns

module dcache_sva
    import dcache_pkg::*;
(
    input logic              clk,
    input logic              rst,
    input logic              rreq_i,
    input logic              wreq_i,
    input logic              stall_i,
    input logic              hit_i,
    input logic              mem_ren_i,
    input logic              mem_rvalid_i,
    input logic              mem_wen_i,
    input logic [ADDR_W-1:0] mem_awaddr_i,
    input line_t             mem_wdata_i,
    input logic              mem_bvalid_i
);

    int unsigned fail_cnt = 0;
    logic        seen_req;

    // first accepted request since reset
    always_ff @(posedge clk) begin
        if (rst) begin
            seen_req <= 1'b0;
        end else if ((rreq_i || wreq_i) && !stall_i) begin
            seen_req <= 1'b1;
        end
    end

    rd_wr_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(mem_ren_i && mem_wen_i))
    else begin
        fail_cnt++;
        $error("mem_ren_o and mem_wen_o high in the same cycle");
    end

    ren_held: assert property (@(posedge clk) disable iff (rst)
        mem_ren_i && !mem_rvalid_i |=> mem_ren_i)
    else begin
        fail_cnt++;
        $error("mem_ren_o dropped before mem_rvalid_i");
    end

    wen_held: assert property (@(posedge clk) disable iff (rst)
        mem_wen_i && !mem_bvalid_i |=> mem_wen_i && $stable(mem_awaddr_i)
                                       && $stable(mem_wdata_i))
    else begin
        fail_cnt++;
        $error("write-back channel changed before mem_bvalid_i");
    end

    no_early_hit: assert property (@(posedge clk) disable iff (rst)
        !seen_req |-> !hit_i)
    else begin
        fail_cnt++;
        $error("hit_o high before any request");
    end

endmodule

bind dcache_top dcache_sva u_sva (
    .clk          (clk),
    .rst          (rst),
    .rreq_i       (rreq_i),
    .wreq_i       (wreq_i),
    .stall_i      (stall_o),
    .hit_i        (hit_o),
    .mem_ren_i    (mem_ren_o),
    .mem_rvalid_i (mem_rvalid_i),
    .mem_wen_i    (mem_wen_o),
    .mem_awaddr_i (mem_awaddr_o),
    .mem_wdata_i  (mem_wdata_o),
    .mem_bvalid_i (mem_bvalid_i)
);

/* verification/dcache_tb.sv */
`timescale 1ns/1ns

module dcache_tb
    import dcache_pkg::*;
();

    localparam int NUM_SETS = 64;
    localparam int IDX_W    = $clog2(NUM_SETS);

    typedef struct packed {
        logic        is_write;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wsel;
        logic        exp_hit;
        logic        early;
    } row_t;

    logic              clk           = 1'b0;
    logic              rst           = 1'b1;
    logic              rreq_i        = 1'b0;
    logic              wreq_i        = 1'b0;
    logic [ADDR_W-1:0] addr_i        = '0;
    logic [WORD_W-1:0] wdata_i       = '0;
    logic [3:0]        wsel_i        = '0;
    logic              mem_rvalid_i  = 1'b0;
    line_t             mem_rdata_i   = '0;
    logic              mem_bvalid_i  = 1'b0;
    logic              stall_o;
    logic              hit_o;
    logic [WORD_W-1:0] rdata_o;
    logic              rdata_valid_o;
    logic              mem_ren_o;
    logic [ADDR_W-1:0] mem_araddr_o;
    logic              mem_wen_o;
    logic [ADDR_W-1:0] mem_awaddr_o;
    line_t             mem_wdata_o;

    row_t        rows [$];
    logic [31:0] mem_words [logic [31:0]];
    logic [31:0] img_words [logic [31:0]];
    logic [31:0] ref_tag   [2][NUM_SETS];
    logic        ref_valid [2][NUM_SETS];
    logic        ref_dirty [2][NUM_SETS];
    logic        ref_lru   [NUM_SETS];
    logic [1:0]  delay_pool [64];
    logic [5:0]  pool_idx    = '0;
    int unsigned cycles      = 0;
    int unsigned cycle_limit = 0;
    int unsigned accepts     = 0;
    int unsigned rd_wait     = 0;
    int unsigned wr_wait     = 0;
    logic        rd_busy     = 1'b0;
    logic        wr_busy     = 1'b0;

    dcache_top #(
        .NUM_SETS (NUM_SETS)
    ) u_dut (
        .clk           (clk),
        .rst           (rst),
        .rreq_i        (rreq_i),
        .wreq_i        (wreq_i),
        .addr_i        (addr_i),
        .wdata_i       (wdata_i),
        .wsel_i        (wsel_i),
        .stall_o       (stall_o),
        .hit_o         (hit_o),
        .rdata_o       (rdata_o),
        .rdata_valid_o (rdata_valid_o),
        .mem_ren_o     (mem_ren_o),
        .mem_araddr_o  (mem_araddr_o),
        .mem_rvalid_i  (mem_rvalid_i),
        .mem_rdata_i   (mem_rdata_i),
        .mem_wen_o     (mem_wen_o),
        .mem_awaddr_o  (mem_awaddr_o),
        .mem_wdata_o   (mem_wdata_o),
        .mem_bvalid_i  (mem_bvalid_i)
    );

    always #4 clk = ~clk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic compare_val(input string name, input logic [LINE_W-1:0] got,
                               input logic [LINE_W-1:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("ERR %s got %0h expected %0h", name, got, exp));
        end
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (u_dut.u_sva.fail_cnt != 0) begin
            fail_run("a protocol assertion on the cache ports failed during the run");
        end else if (cycle_limit != 0 && cycles >= cycle_limit) begin
            fail_run("timeout: the cache did not finish the table within the cycle limit");
        end
    end

    //////////////////////////////
    // memory model
    //////////////////////////////

    // unwritten memory is a pattern of the full address
    function automatic logic [31:0] fill_value(input logic [31:0] a);
        return a ^ 32'h5a5a_0000;
    endfunction

    function automatic logic [31:0] memory_word(input logic [31:0] a);
        if (mem_words.exists(a)) begin
            return mem_words[a];
        end
        return fill_value(a);
    endfunction

    function automatic logic [31:0] image_word(input logic [31:0] a);
        logic [31:0] w;
        w = {a[31:2], 2'b00};
        if (img_words.exists(w)) begin
            return img_words[w];
        end
        return fill_value(w);
    endfunction

    function automatic logic [LINE_W-1:0] read_line(input logic [31:0] base);
        logic [LINE_W-1:0] line;
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            line[WORD_W*w +: WORD_W] = memory_word(base + 4 * w);
        end
        return line;
    endfunction

    function automatic logic [LINE_W-1:0] image_line(input logic [31:0] base);
        logic [LINE_W-1:0] line;
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            line[WORD_W*w +: WORD_W] = image_word(base + 4 * w);
        end
        return line;
    endfunction

    // refill channel acks 1 to 4 cycles after the request
    always @(posedge clk) begin
        if (mem_rvalid_i) begin
            mem_rvalid_i <= 1'b0;
            rd_busy = 1'b0;
        end else if (mem_ren_o && !rd_busy) begin
            rd_busy  = 1'b1;
            rd_wait  = delay_pool[pool_idx] + 1;
            pool_idx = pool_idx + 1;
        end else if (rd_busy) begin
            rd_wait = rd_wait - 1;
            if (rd_wait == 0) begin
                mem_rvalid_i     <= 1'b1;
                mem_rdata_i.flat <= read_line(mem_araddr_o);
            end
        end
    end

    // write-back line lands in memory on the ack
    always @(posedge clk) begin
        if (mem_bvalid_i) begin
            mem_bvalid_i <= 1'b0;
            wr_busy = 1'b0;
            for (int w = 0; w < WORDS_PER_LINE; w++) begin
                mem_words[mem_awaddr_o + 4 * w] = mem_wdata_o.words[w];
            end
        end else if (mem_wen_o && !wr_busy) begin
            wr_busy  = 1'b1;
            wr_wait  = delay_pool[pool_idx] + 1;
            pool_idx = pool_idx + 1;
        end else if (wr_busy) begin
            wr_wait = wr_wait - 1;
            if (wr_wait == 0) begin
                mem_bvalid_i <= 1'b1;
            end
        end
    end

    always @(negedge clk) begin
        if (!rst && (rreq_i || wreq_i) && !stall_o) begin
            accepts = accepts + 1;
        end
    end

    //////////////////////////////
    // stimulus and reference
    //////////////////////////////

    task automatic add_row(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                           input logic [3:0] wsel, input logic exp_hit, input logic early);
        row_t row;
        row.is_write = wr;
        row.addr     = addr;
        row.wdata    = wdata;
        row.wsel     = wsel;
        row.exp_hit  = exp_hit;
        row.early    = early;
        rows.push_back(row);
    endtask

    task automatic build_table();
        //      wr    addr          wdata         wsel     hit   early
        add_row(1'b0, 32'h0000_1044, 32'h0,        4'b0000, 1'b0, 1'b0);
        add_row(1'b0, 32'h0000_1058, 32'h0,        4'b0000, 1'b1, 1'b0);
        add_row(1'b1, 32'h0000_1048, 32'hdead_beef, 4'b0110, 1'b1, 1'b0);
        add_row(1'b0, 32'h0000_1048, 32'h0,        4'b0000, 1'b1, 1'b1);
        add_row(1'b1, 32'h0000_2464, 32'ha5a5_1234, 4'b0011, 1'b0, 1'b0);
        add_row(1'b0, 32'h0000_2464, 32'h0,        4'b0000, 1'b1, 1'b0);
        add_row(1'b0, 32'h0000_2470, 32'h0,        4'b0000, 1'b1, 1'b1);
        // three more tags in set 2 push dirty victims back to memory
        add_row(1'b0, 32'h0000_1840, 32'h0,        4'b0000, 1'b0, 1'b0);
        add_row(1'b1, 32'h0000_2040, 32'h1357_9bdf, 4'b1111, 1'b0, 1'b1);
        add_row(1'b0, 32'h0000_1048, 32'h0,        4'b0000, 1'b0, 1'b0);
        add_row(1'b0, 32'h0000_2840, 32'h0,        4'b0000, 1'b0, 1'b0);
        add_row(1'b0, 32'h0000_2040, 32'h0,        4'b0000, 1'b0, 1'b0);
        add_row(1'b0, 32'h0000_2848, 32'h0,        4'b0000, 1'b1, 1'b0);
    endtask

    task automatic drive_req(input row_t row);
        rreq_i  <= !row.is_write;
        wreq_i  <= row.is_write;
        addr_i  <= row.addr;
        wdata_i <= row.wdata;
        wsel_i  <= row.wsel;
    endtask

    // byte-enabled write into the cpu view of memory
    task automatic write_image(input row_t row);
        logic [31:0] a;
        logic [31:0] v;
        a = {row.addr[31:2], 2'b00};
        v = image_word(a);
        for (int b = 0; b < 4; b++) begin
            if (row.wsel[b]) begin
                v[8*b +: 8] = row.wdata[8*b +: 8];
            end
        end
        img_words[a] = v;
    endtask

    task automatic run_row(input int r);
        row_t             row;
        logic [IDX_W-1:0] idx;
        logic [31:0]      tag;
        logic [31:0]      victim_addr;
        logic             ref_hit;
        logic             ref_way;
        logic             way;
        logic             dirty;
        logic             wb_seen;
        row     = rows[r];
        idx     = row.addr[OFFSET_W +: IDX_W];
        tag     = row.addr >> (OFFSET_W + IDX_W);
        ref_hit = 1'b0;
        ref_way = 1'b0;
        wb_seen = 1'b0;
        if (!row.early) begin
            @(posedge clk);
            drive_req(row);
            @(negedge clk);
        end
        while (stall_o) begin
            @(negedge clk);
        end
        // acceptance edge where an early next row gets raised
        @(posedge clk);
        if (r + 1 < rows.size() && rows[r + 1].early) begin
            drive_req(rows[r + 1]);
        end else begin
            rreq_i <= 1'b0;
            wreq_i <= 1'b0;
        end
        @(negedge clk);
        compare_val("accepted requests", accepts, r + 1);
        compare_val("stall_o", stall_o, 1'b1);
        compare_val("hit_o", hit_o, row.exp_hit);
        for (int w = 0; w < 2; w++) begin
            if (ref_valid[w][idx] && ref_tag[w][idx] == tag) begin
                ref_hit = 1'b1;
                ref_way = w[0];
            end
        end
        compare_val("reference hit", ref_hit, row.exp_hit);
        if (ref_hit) begin
            compare_val("rdata_valid_o", rdata_valid_o, !row.is_write);
            ref_lru[idx] = ~ref_way;
            if (row.is_write) begin
                ref_dirty[ref_way][idx] = 1'b1;
                write_image(row);
                do begin
                    @(negedge clk);
                end while (stall_o);
            end else begin
                compare_val("rdata_o", rdata_o, image_word(row.addr));
            end
        end else begin
            way         = ref_lru[idx];
            dirty       = ref_valid[way][idx] && ref_dirty[way][idx];
            victim_addr = (ref_tag[way][idx] << (OFFSET_W + IDX_W)) | (32'(idx) << OFFSET_W);
            do begin
                @(negedge clk);
                if (mem_wen_o && !wb_seen) begin
                    wb_seen = 1'b1;
                    compare_val("write-back of a dirty victim", dirty, 1'b1);
                    compare_val("mem_awaddr_o", mem_awaddr_o, victim_addr);
                    compare_val("mem_wdata_o", mem_wdata_o, image_line(victim_addr));
                end
            end while (!mem_ren_o);
            compare_val("write-back seen", wb_seen, dirty);
            compare_val("mem_araddr_o", mem_araddr_o, {row.addr[31:OFFSET_W], 5'b0});
            if (row.is_write) begin
                write_image(row);
                while (stall_o) begin
                    @(negedge clk);
                end
            end else begin
                while (!rdata_valid_o) begin
                    @(negedge clk);
                end
                compare_val("mem_rvalid_i", mem_rvalid_i, 1'b1);
                compare_val("rdata_o", rdata_o, image_word(row.addr));
            end
            ref_tag[way][idx]   = tag;
            ref_valid[way][idx] = 1'b1;
            ref_dirty[way][idx] = row.is_write;
            ref_lru[idx]        = ~ref_lru[idx];
        end
    endtask

    initial begin
        void'($urandom(32'h880b9abf));
        for (int i = 0; i < 64; i++) begin
            delay_pool[i] = $urandom_range(3, 0);
        end
        for (int s = 0; s < NUM_SETS; s++) begin
            ref_valid[0][s] = 1'b0;
            ref_valid[1][s] = 1'b0;
            ref_dirty[0][s] = 1'b0;
            ref_dirty[1][s] = 1'b0;
            ref_lru[s]      = 1'b0;
        end
        build_table();
        cycle_limit = 30 * rows.size() + 50;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        compare_val("stall_o", stall_o, 1'b0);
        compare_val("hit_o", hit_o, 1'b0);
        compare_val("rdata_valid_o", rdata_valid_o, 1'b0);
        compare_val("mem_ren_o", mem_ren_o, 1'b0);
        compare_val("mem_wen_o", mem_wen_o, 1'b0);
        for (int r = 0; r < rows.size(); r++) begin
            run_row(r);
        end
        @(negedge clk);
        if (u_dut.u_sva.fail_cnt != 0) begin
            fail_run("a protocol assertion on the cache ports failed during the run");
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

/* dcache_top.f */
rtl/dcache_pkg.sv
rtl/dcache_ctrl.sv
rtl/dcache_tag_store.sv
rtl/dcache_data_store.sv
rtl/dcache_mem_port.sv
rtl/dcache_top.sv
verification/dcache_sva.sv
verification/dcache_tb.sv

/* Bender.yml */
package:
  name: dcache

sources:
  - files:
      - rtl/dcache_pkg.sv
      - rtl/dcache_ctrl.sv
      - rtl/dcache_tag_store.sv
      - rtl/dcache_data_store.sv
      - rtl/dcache_mem_port.sv
      - rtl/dcache_top.sv
  - target: test
    files:
      - verification/dcache_sva.sv
      - verification/dcache_tb.sv
